// ==== verilog/tcp_rx_pkg.sv ====
package tcp_rx_pkg;

  // IPv4 protocol number for TCP
  localparam logic [7:0] PROTO_TCP = 8'd6;

  // fixed part of the TCP header
  localparam int TCP_HDR_LEN = 20;

  // byte that holds the data offset nibble
  localparam int HDR_OFFSET_POS = 12;

  // option kind codes
  localparam logic [7:0] OPT_END       = 8'd0;
  localparam logic [7:0] OPT_NOP       = 8'd1;
  localparam logic [7:0] OPT_MSS       = 8'd2;
  localparam logic [7:0] OPT_WND       = 8'd3;
  localparam logic [7:0] OPT_SACK_PERM = 8'd4;
  localparam logic [7:0] OPT_SACK      = 8'd5;
  localparam logic [7:0] OPT_TS        = 8'd8;

  // part of an option the walker expects next
  typedef enum logic [1:0] {
    kind_f = 2'd0,
    len_f  = 2'd1,
    data_f = 2'd2
  } opt_field_t;

  typedef logic [15:0] length_t;

endpackage : tcp_rx_pkg

// ==== verilog/ipv4_proto_filter.sv ====
`timescale 1ns/1ps

module ipv4_proto_filter (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                frame_clr,
  input  logic [7:0]          in_dat,
  input  logic                in_val,
  input  logic                in_sof,
  input  logic                in_eof,
  input  logic [7:0]          in_proto,
  input  tcp_rx_pkg::length_t in_pld_len,
  output logic [7:0]          b_dat,
  output logic                b_val,
  output tcp_rx_pkg::length_t b_idx,
  output tcp_rx_pkg::length_t frm_len
);

  logic acc;
  logic is_tcp;
  logic take;

  assign is_tcp = (in_proto == tcp_rx_pkg::PROTO_TCP);

  // the sof byte decides on the protocol, later bytes follow the flag
  assign take = in_val && (in_sof ? is_tcp : acc);

  always_ff @(posedge clk) begin
    if (fsm_rst || frame_clr) begin
      acc   <= 1'b0;
      b_val <= 1'b0;
      b_idx <= '0;
    end else begin
      b_val <= take;
      if (in_val && in_sof) begin
        acc <= is_tcp && !in_eof;
      end else if (take && in_eof) begin
        // nothing more belongs to this frame
        acc <= 1'b0;
      end
      if (take) begin
        b_idx <= in_sof ? '0 : b_idx + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      b_dat <= in_dat;
    end
    if (take && in_sof) begin
      frm_len <= in_pld_len;
    end
  end

endmodule : ipv4_proto_filter

// ==== verilog/tcp_hdr_parser.sv ====
`timescale 1ns/1ps

module tcp_hdr_parser (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                frame_clr,
  input  logic [7:0]          b_dat,
  input  logic                b_val,
  input  tcp_rx_pkg::length_t b_idx,
  output tcp_rx_pkg::length_t off_bytes,
  output logic                hdr_done,
  output logic [15:0]         src_port,
  output logic [15:0]         dst_port,
  output logic [31:0]         seq_num,
  output logic [31:0]         ack_num,
  output logic [8:0]          flags,
  output logic [15:0]         window,
  output logic                hdr_val,
  output logic                hdr_err
);

  logic [tcp_rx_pkg::TCP_HDR_LEN-1:0][7:0] hdr_sr;
  logic [tcp_rx_pkg::TCP_HDR_LEN*8-1:0]    hdr_word;
  tcp_rx_pkg::length_t                     off_raw;
  logic                                    in_hdr;
  logic                                    last_hdr;

  assign in_hdr   = b_val && (b_idx < tcp_rx_pkg::TCP_HDR_LEN);
  assign last_hdr = b_val && (b_idx == tcp_rx_pkg::TCP_HDR_LEN - 1);

  // header byte 0 ends up in the top byte, current byte closes the word
  assign hdr_word = {hdr_sr[tcp_rx_pkg::TCP_HDR_LEN-2:0], b_dat};

  // data offset is counted in 32-bit words
  assign off_raw = {10'd0, b_dat[7:4], 2'b00};

  always_ff @(posedge clk) begin
    if (in_hdr) begin
      hdr_sr <= {hdr_sr[tcp_rx_pkg::TCP_HDR_LEN-2:0], b_dat};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      off_bytes <= tcp_rx_pkg::length_t'(tcp_rx_pkg::TCP_HDR_LEN);
      hdr_done  <= 1'b0;
      hdr_val   <= 1'b0;
      hdr_err   <= 1'b0;
    end else begin
      hdr_done <= last_hdr;
      hdr_val  <= last_hdr;
      if (frame_clr) begin
        off_bytes <= tcp_rx_pkg::length_t'(tcp_rx_pkg::TCP_HDR_LEN);
      end else if (b_val && b_idx == tcp_rx_pkg::HDR_OFFSET_POS) begin
        // a short offset is forced up to the fixed header
        if (off_raw < tcp_rx_pkg::TCP_HDR_LEN) begin
          off_bytes <= tcp_rx_pkg::length_t'(tcp_rx_pkg::TCP_HDR_LEN);
          hdr_err   <= 1'b1;
        end else begin
          off_bytes <= off_raw;
          hdr_err   <= 1'b0;
        end
      end
    end
  end

  // checksum and urgent pointer are not kept
  always_ff @(posedge clk) begin
    if (last_hdr) begin
      src_port <= hdr_word[159:144];
      dst_port <= hdr_word[143:128];
      seq_num  <= hdr_word[127:96];
      ack_num  <= hdr_word[95:64];
      flags    <= hdr_word[56:48];
      window   <= hdr_word[47:32];
    end
  end

endmodule : tcp_hdr_parser

// ==== verilog/tcp_opt_parser.sv ====
`timescale 1ns/1ps

module tcp_opt_parser #(
  parameter int MAX_OPT_BYTES = 40
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                frame_clr,
  input  logic [7:0]          b_dat,
  input  logic                b_val,
  input  tcp_rx_pkg::length_t b_idx,
  input  tcp_rx_pkg::length_t off_bytes,
  input  logic                hdr_done,
  output logic                opt_done,
  output logic                mss_pres,
  output logic [15:0]         mss,
  output logic                wnd_pres,
  output logic [7:0]          wnd_scale,
  output logic                sack_perm_pres,
  output logic [2:0]          sack_blocks,
  output logic                ts_pres,
  output logic [31:0]         ts_val,
  output logic                opt_val
);

  localparam int CNT_W = $clog2(MAX_OPT_BYTES + 1);

  tcp_rx_pkg::opt_field_t field;
  logic [7:0]             cur_kind;
  logic [7:0]             prev_dat;
  logic [CNT_W-1:0]       opt_len;
  logic [CNT_W-1:0]       data_cnt;
  logic                   in_opt;
  logic                   last_data;

  assign in_opt = b_val && (b_idx >= tcp_rx_pkg::TCP_HDR_LEN) && (b_idx < off_bytes);
  assign last_data = (data_cnt == opt_len - 1'b1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      field    <= tcp_rx_pkg::kind_f;
      data_cnt <= '0;
      opt_done <= 1'b0;
      opt_val  <= 1'b0;
    end else begin
      // last option byte, or header byte 19 when there are none
      opt_done <= b_val && (b_idx == off_bytes - 16'd1);
      opt_val  <= opt_done;
      if (frame_clr) begin
        field    <= tcp_rx_pkg::kind_f;
        data_cnt <= '0;
      end else if (in_opt) begin
        case (field)
          tcp_rx_pkg::kind_f: begin
            // END and NOP are single bytes, every other kind has a length
            if (b_dat != tcp_rx_pkg::OPT_END && b_dat != tcp_rx_pkg::OPT_NOP) begin
              field <= tcp_rx_pkg::len_f;
            end
          end
          tcp_rx_pkg::len_f: begin
            data_cnt <= '0;
            field    <= (b_dat > 8'd2) ? tcp_rx_pkg::data_f : tcp_rx_pkg::kind_f;
          end
          default: begin
            data_cnt <= data_cnt + 1'b1;
            if (last_data) begin
              field <= tcp_rx_pkg::kind_f;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_opt) begin
      prev_dat <= b_dat;
      if (field == tcp_rx_pkg::kind_f) begin
        cur_kind <= b_dat;
      end
      if (field == tcp_rx_pkg::len_f) begin
        opt_len <= CNT_W'(b_dat - 8'd2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      mss_pres       <= 1'b0;
      wnd_pres       <= 1'b0;
      sack_perm_pres <= 1'b0;
      ts_pres        <= 1'b0;
      sack_blocks    <= '0;
    end else begin
      // results of the previous frame stay until the next header is in
      if (hdr_done) begin
        mss_pres       <= 1'b0;
        wnd_pres       <= 1'b0;
        sack_perm_pres <= 1'b0;
        ts_pres        <= 1'b0;
        sack_blocks    <= '0;
      end
      if (in_opt && field == tcp_rx_pkg::kind_f) begin
        case (b_dat)
          tcp_rx_pkg::OPT_MSS:       mss_pres       <= 1'b1;
          tcp_rx_pkg::OPT_WND:       wnd_pres       <= 1'b1;
          tcp_rx_pkg::OPT_SACK_PERM: sack_perm_pres <= 1'b1;
          tcp_rx_pkg::OPT_TS:        ts_pres        <= 1'b1;
          default: ;
        endcase
      end
      if (in_opt && field == tcp_rx_pkg::len_f && cur_kind == tcp_rx_pkg::OPT_SACK) begin
        case (b_dat)
          8'd10:   sack_blocks <= 3'd1;
          8'd18:   sack_blocks <= 3'd2;
          8'd26:   sack_blocks <= 3'd3;
          8'd34:   sack_blocks <= 3'd4;
          default: sack_blocks <= 3'd0;
        endcase
      end
    end
  end

  // option values
  always_ff @(posedge clk) begin
    if (in_opt && field == tcp_rx_pkg::data_f) begin
      if (cur_kind == tcp_rx_pkg::OPT_MSS && last_data) begin
        mss <= {prev_dat, b_dat};
      end
      if (cur_kind == tcp_rx_pkg::OPT_WND && last_data) begin
        wnd_scale <= b_dat;
      end
      // TSval is the first four data bytes, TSecr is dropped
      if (cur_kind == tcp_rx_pkg::OPT_TS && data_cnt < 4) begin
        ts_val <= {ts_val[23:0], b_dat};
      end
    end
  end

endmodule : tcp_opt_parser

// ==== verilog/tcp_pld_strm.sv ====
`timescale 1ns/1ps

module tcp_pld_strm (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic [7:0]          b_dat,
  input  logic                b_val,
  input  tcp_rx_pkg::length_t b_idx,
  input  tcp_rx_pkg::length_t off_bytes,
  input  tcp_rx_pkg::length_t frm_len,
  input  logic                opt_done,
  output logic [7:0]          out_dat,
  output logic                out_val,
  output logic                out_sof,
  output logic                out_eof,
  output tcp_rx_pkg::length_t pld_len,
  output logic                frame_done,
  output logic                frame_clr
);

  logic in_pld;
  logic no_pld;

  // off_bytes never drops below the fixed header length
  assign in_pld = b_val && (b_idx >= off_bytes);
  assign no_pld = (frm_len == off_bytes);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      out_val    <= 1'b0;
      out_sof    <= 1'b0;
      out_eof    <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      out_val    <= in_pld;
      out_sof    <= in_pld && (b_idx == off_bytes);
      out_eof    <= in_pld && (b_idx == frm_len - 16'd1);
      // an empty frame ends right after its options
      frame_done <= out_eof || (opt_done && no_pld);
    end
  end

  always_ff @(posedge clk) begin
    if (in_pld) begin
      out_dat <= b_dat;
    end
    if (opt_done) begin
      pld_len <= frm_len - off_bytes;
    end
  end

  // the frame is closed in the same cycle it is reported done
  assign frame_clr = frame_done;

endmodule : tcp_pld_strm

// ==== verilog/tcp_rx_top.sv ====
`timescale 1ns/1ps

module tcp_rx_top #(
  parameter int MAX_OPT_BYTES = 40
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic [7:0]          in_dat,
  input  logic                in_val,
  input  logic                in_sof,
  input  logic                in_eof,
  input  logic [7:0]          in_proto,
  input  tcp_rx_pkg::length_t in_pld_len,
  output logic [15:0]         src_port,
  output logic [15:0]         dst_port,
  output logic [31:0]         seq_num,
  output logic [31:0]         ack_num,
  output logic [8:0]          flags,
  output logic [15:0]         window,
  output logic                hdr_val,
  output logic                hdr_err,
  output logic                mss_pres,
  output logic [15:0]         mss,
  output logic                wnd_pres,
  output logic [7:0]          wnd_scale,
  output logic                sack_perm_pres,
  output logic [2:0]          sack_blocks,
  output logic                ts_pres,
  output logic [31:0]         ts_val,
  output logic                opt_val,
  output logic [7:0]          out_dat,
  output logic                out_val,
  output logic                out_sof,
  output logic                out_eof,
  output tcp_rx_pkg::length_t pld_len,
  output logic                frame_done
);

  logic [7:0]          b_dat;
  logic                b_val;
  tcp_rx_pkg::length_t b_idx;
  tcp_rx_pkg::length_t frm_len;
  tcp_rx_pkg::length_t off_bytes;
  logic                hdr_done;
  logic                opt_done;
  logic                frame_clr;

  ipv4_proto_filter u_filter (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .frame_clr  (frame_clr),
    .in_dat     (in_dat),
    .in_val     (in_val),
    .in_sof     (in_sof),
    .in_eof     (in_eof),
    .in_proto   (in_proto),
    .in_pld_len (in_pld_len),
    .b_dat      (b_dat),
    .b_val      (b_val),
    .b_idx      (b_idx),
    .frm_len    (frm_len)
  );

  tcp_hdr_parser u_hdr (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .frame_clr (frame_clr),
    .b_dat     (b_dat),
    .b_val     (b_val),
    .b_idx     (b_idx),
    .off_bytes (off_bytes),
    .hdr_done  (hdr_done),
    .src_port  (src_port),
    .dst_port  (dst_port),
    .seq_num   (seq_num),
    .ack_num   (ack_num),
    .flags     (flags),
    .window    (window),
    .hdr_val   (hdr_val),
    .hdr_err   (hdr_err)
  );

  tcp_opt_parser #(
    .MAX_OPT_BYTES (MAX_OPT_BYTES)
  ) u_opt (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .frame_clr      (frame_clr),
    .b_dat          (b_dat),
    .b_val          (b_val),
    .b_idx          (b_idx),
    .off_bytes      (off_bytes),
    .hdr_done       (hdr_done),
    .opt_done       (opt_done),
    .mss_pres       (mss_pres),
    .mss            (mss),
    .wnd_pres       (wnd_pres),
    .wnd_scale      (wnd_scale),
    .sack_perm_pres (sack_perm_pres),
    .sack_blocks    (sack_blocks),
    .ts_pres        (ts_pres),
    .ts_val         (ts_val),
    .opt_val        (opt_val)
  );

  tcp_pld_strm u_pld (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .b_dat      (b_dat),
    .b_val      (b_val),
    .b_idx      (b_idx),
    .off_bytes  (off_bytes),
    .frm_len    (frm_len),
    .opt_done   (opt_done),
    .out_dat    (out_dat),
    .out_val    (out_val),
    .out_sof    (out_sof),
    .out_eof    (out_eof),
    .pld_len    (pld_len),
    .frame_done (frame_done),
    .frame_clr  (frame_clr)
  );

endmodule : tcp_rx_top

// ==== tb/tcp_rx_sva.sv ====
`timescale 1ns/1ps

module tcp_rx_sva (
  input logic clk,
  input logic fsm_rst,
  input logic out_val,
  input logic out_sof,
  input logic out_eof,
  input logic hdr_val,
  input logic opt_val,
  input logic frame_done
);

  // frame markers only ride on valid payload bytes
  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst) out_sof |-> out_val)
    else $error("out_sof raised without out_val");

  eof_with_val: assert property (@(posedge clk) disable iff (fsm_rst) out_eof |-> out_val)
    else $error("out_eof raised without out_val");

  // result strobes last one cycle
  hdr_val_pulse: assert property (@(posedge clk) disable iff (fsm_rst) hdr_val |=> !hdr_val)
    else $error("hdr_val held for more than one cycle");

  opt_val_pulse: assert property (@(posedge clk) disable iff (fsm_rst) opt_val |=> !opt_val)
    else $error("opt_val held for more than one cycle");

  done_pulse: assert property (@(posedge clk) disable iff (fsm_rst) frame_done |=> !frame_done)
    else $error("frame_done held for more than one cycle");

endmodule : tcp_rx_sva

bind tcp_rx_top tcp_rx_sva u_sva (.*);

// ==== tb/tcp_rx_checker.sv ====
`timescale 1ns/1ps

module tcp_rx_checker (
  input logic        clk,
  input logic        fsm_rst,
  input logic [15:0] src_port,
  input logic [15:0] dst_port,
  input logic [31:0] seq_num,
  input logic [31:0] ack_num,
  input logic [8:0]  flags,
  input logic [15:0] window,
  input logic        hdr_val,
  input logic        hdr_err,
  input logic        mss_pres,
  input logic [15:0] mss,
  input logic        wnd_pres,
  input logic [7:0]  wnd_scale,
  input logic        sack_perm_pres,
  input logic [2:0]  sack_blocks,
  input logic        ts_pres,
  input logic [31:0] ts_val,
  input logic        opt_val,
  input logic [7:0]  out_dat,
  input logic        out_val,
  input logic        out_sof,
  input logic        out_eof,
  input logic [15:0] pld_len,
  input logic        frame_done
);

  // expected header, option set and {sof, eof, byte} per payload byte
  logic [121:0] hdr_q [$];
  logic [78:0]  opt_q [$];
  logic [9:0]   pld_q [$];
  int           frames_exp = 0;
  int           frames_seen = 0;
  int           check_cnt = 0;
  int           err_cnt = 0;
  logic         hdr_val_d = 1'b0;
  logic         opt_val_d = 1'b0;
  logic         done_d = 1'b0;

  task automatic add_frame(input logic [121:0] hdr, input logic [78:0] opt);
    hdr_q.push_back(hdr);
    opt_q.push_back(opt);
    frames_exp++;
  endtask

  task automatic add_byte(input logic [9:0] b);
    pld_q.push_back(b);
  endtask

  task automatic check_field(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail @%0t ns: %s expected %0h, got %0h", $time, what, exp, got);
    end
  endtask

  task automatic report(input string msg);
    err_cnt++;
    $display("%s at %0t ns", msg, $time);
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    logic [121:0] eh;
    logic [78:0]  eo;
    logic [9:0]   ep;
    if (!fsm_rst) begin
      if (hdr_val && hdr_q.size() == 0) begin
        report("hdr_val came while no TCP frame was pending");
      end else if (hdr_val) begin
        eh = hdr_q.pop_front();
        check_field("src_port", eh[121:106], src_port);
        check_field("dst_port", eh[105:90], dst_port);
        check_field("seq_num", eh[89:58], seq_num);
        check_field("ack_num", eh[57:26], ack_num);
        check_field("flags", eh[25:17], flags);
        check_field("window", eh[16:1], window);
        check_field("hdr_err", eh[0], hdr_err);
      end
      if (opt_val && opt_q.size() == 0) begin
        report("opt_val came while no TCP frame was pending");
      end else if (opt_val) begin
        eo = opt_q.pop_front();
        check_field("mss_pres", eo[78], mss_pres);
        if (eo[78]) check_field("mss", eo[77:62], mss);
        check_field("wnd_pres", eo[61], wnd_pres);
        if (eo[61]) check_field("wnd_scale", eo[60:53], wnd_scale);
        check_field("sack_perm_pres", eo[52], sack_perm_pres);
        check_field("sack_blocks", eo[51:49], sack_blocks);
        check_field("ts_pres", eo[48], ts_pres);
        if (eo[48]) check_field("ts_val", eo[47:16], ts_val);
        check_field("pld_len", eo[15:0], pld_len);
      end
      if (out_val && pld_q.size() == 0) begin
        report("out_val came with no payload byte expected");
      end else if (out_val) begin
        ep = pld_q.pop_front();
        check_field("out_sof", ep[9], out_sof);
        check_field("out_eof", ep[8], out_eof);
        check_field("out_dat", ep[7:0], out_dat);
      end
      if ((out_sof || out_eof) && !out_val) begin
        report("stream marker seen without out_val");
      end
      if ((hdr_val && hdr_val_d) || (opt_val && opt_val_d) || (frame_done && done_d)) begin
        report("strobe held longer than one cycle");
      end
      if (frame_done) begin
        frames_seen++;
      end
    end
    hdr_val_d <= hdr_val;
    opt_val_d <= opt_val;
    done_d    <= frame_done;
  end

  task automatic final_checks();
    check_cnt++;
    if (frames_seen != frames_exp) begin
      report($sformatf("saw %0d frame_done pulses instead of %0d", frames_seen, frames_exp));
    end
    if (hdr_q.size() != 0 || opt_q.size() != 0 || pld_q.size() != 0) begin
      report($sformatf("%0d headers, %0d option sets, %0d payload bytes never came out",
                       hdr_q.size(), opt_q.size(), pld_q.size()));
    end
  endtask

endmodule : tcp_rx_checker

// ==== tb/tcp_rx_tb.sv ====
`timescale 1ns/1ps

module tcp_rx_tb;

  logic                clk = 1'b0;
  logic                fsm_rst;
  logic [7:0]          in_dat;
  logic                in_val;
  logic                in_sof;
  logic                in_eof;
  logic [7:0]          in_proto;
  tcp_rx_pkg::length_t in_pld_len;

  logic [15:0]         src_port;
  logic [15:0]         dst_port;
  logic [31:0]         seq_num;
  logic [31:0]         ack_num;
  logic [8:0]          flags;
  logic [15:0]         window;
  logic                hdr_val;
  logic                hdr_err;
  logic                mss_pres;
  logic [15:0]         mss;
  logic                wnd_pres;
  logic [7:0]          wnd_scale;
  logic                sack_perm_pres;
  logic [2:0]          sack_blocks;
  logic                ts_pres;
  logic [31:0]         ts_val;
  logic                opt_val;
  logic [7:0]          out_dat;
  logic                out_val;
  logic                out_sof;
  logic                out_eof;
  tcp_rx_pkg::length_t pld_len;
  logic                frame_done;

  // current case as read from the file
  int              fd;
  int              proto;
  int              len;
  int              n_cases = 0;
  int              cycles = 0;
  int              cycle_limit = 50;
  logic [7:0]      frm_bytes [256];
  logic [15:0]     e_src, e_dst, e_win, e_mss, e_pld;
  logic [31:0]     e_seq, e_ack, e_ts;
  logic [8:0]      e_flags;
  logic [7:0]      e_scale;
  logic [2:0]      e_blocks;
  logic            e_err, e_mss_p, e_wnd_p, e_sackp, e_ts_p;

  tcp_rx_top #(
    .MAX_OPT_BYTES (40)
  ) DUT (.*);

  tcp_rx_checker chk (.*);

  always #20 clk = ~clk;

  // budget grows with every frame read
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("cases %0d, checks %0d, errors %0d", n_cases, chk.check_cnt, chk.err_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic read_case(output bit got);
    logic [8*16-1:0]  tok;
    logic [8*128-1:0] line;
    logic [7:0]       byte_in;
    int               code;
    got = 1'b0;
    code = $fscanf(fd, "%s", tok);
    // comment lines are dropped up to their end
    while (code == 1 && tok == "#") begin
      code = $fgets(line, fd);
      code = $fscanf(fd, "%s", tok);
    end
    if (code == 1 && tok == "frame") begin
      code = $fscanf(fd, "%d %d", proto, len);
      for (int i = 0; i < len; i++) begin
        code = $fscanf(fd, "%h", byte_in);
        frm_bytes[i] = byte_in;
      end
      code = $fscanf(fd, "%s", tok);
      code = $fscanf(fd, "%h %h %h %h %h %h %h",
                     e_src, e_dst, e_seq, e_ack, e_flags, e_win, e_err);
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                     e_mss_p, e_mss, e_wnd_p, e_scale, e_sackp, e_blocks, e_ts_p, e_ts, e_pld);
      got = (code == 9);
    end
  endtask

  // header length from the offset nibble, short offsets count as 20 bytes
  function automatic int hdr_bytes();
    int off;
    off = int'(frm_bytes[12][7:4]) * 4;
    if (off < 20) begin
      off = 20;
    end
    return off;
  endfunction

  task automatic queue_expect();
    int off;
    off = hdr_bytes();
    chk.add_frame({e_src, e_dst, e_seq, e_ack, e_flags, e_win, e_err},
                  {e_mss_p, e_mss, e_wnd_p, e_scale, e_sackp, e_blocks, e_ts_p, e_ts, e_pld});
    for (int i = off; i < len; i++) begin
      chk.add_byte({i == off, i == len - 1, frm_bytes[i]});
    end
  endtask

  task automatic drive_frame();
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      #1;
      in_val     = 1'b1;
      in_sof     = (i == 0);
      in_eof     = (i == len - 1);
      in_dat     = frm_bytes[i];
      in_proto   = proto[7:0];
      in_pld_len = len[15:0];
    end
    @(posedge clk);
    #1;
    in_val = 1'b0;
    in_sof = 1'b0;
    in_eof = 1'b0;
  endtask

  initial begin
    bit got;
    fsm_rst    = 1'b1;
    in_dat     = '0;
    in_val     = 1'b0;
    in_sof     = 1'b0;
    in_eof     = 1'b0;
    in_proto   = '0;
    in_pld_len = '0;
    fd = $fopen("tb/tcp_rx_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/tcp_rx_cases.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      #1;
      fsm_rst = 1'b0;
      read_case(got);
      while (got) begin
        n_cases++;
        cycle_limit += len + 10;
        if (proto == int'(tcp_rx_pkg::PROTO_TCP)) begin
          queue_expect();
        end
        drive_frame();
        // only TCP frames report their end
        if (proto == int'(tcp_rx_pkg::PROTO_TCP)) begin
          while (!frame_done) begin
            @(posedge clk);
            #1;
          end
        end
        repeat (3) @(posedge clk);
        read_case(got);
      end
      $fclose(fd);
      repeat (4) @(posedge clk);
      chk.final_checks();
      if (n_cases == 0) begin
        $display("no cases were read from the case file");
      end
      $display("cases %0d, checks %0d, errors %0d", n_cases, chk.check_cnt, chk.err_cnt);
      if (chk.err_cnt == 0 && n_cases > 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule : tcp_rx_tb

// ==== tb/tcp_rx_cases.txt ====
# frame <protocol> <ip payload length>, then that many bytes in hex
# expect src dst seq ack flags win err mss_p mss wnd_p scale sackp blocks ts_p ts pld_len
# UDP frame, must be dropped
frame 17 12
00 35 04 d2 00 0c 00 00 11 22 33 44
expect 0000 0000 00000000 00000000 000 0000 0 0 0000 0 00 0 0 0 00000000 0000
# plain header, 4 payload bytes
frame 6 24
1f 90 c3 50 01 02 03 04 a0 b0 c0 d0 50 18 fa f0 12 34 00 00
de ad be ef
expect 1f90 c350 01020304 a0b0c0d0 018 faf0 0 0 0000 0 00 0 0 0 00000000 0004
# NOP MSS WS SACK(18) TS END, 6 payload bytes
frame 6 66
00 50 d4 31 11 22 33 44 55 66 77 88 f0 10 02 00 be ef 00 00
01 02 04 05 b4 03 03 07 05 12 00 00 10 00 00 00 20 00 00 00
30 00 00 00 40 00 08 0a 89 ab cd ef 01 02 03 04 00 00 00 00
48 65 6c 6c 6f 21
expect 0050 d431 11223344 55667788 010 0200 0 1 05b4 1 07 0 2 1 89abcdef 0006
# SYN without payload, MSS SACK-perm TS NOP WS and an unknown kind
frame 6 44
c0 01 00 16 de ad be ef 00 00 00 00 b0 02 ff ff 00 00 00 00
02 04 02 18 04 02 08 0a 00 00 00 2a 00 00 00 00 01 03 03 0e
22 04 aa bb
expect c001 0016 deadbeef 00000000 002 ffff 0 1 0218 1 0e 1 0 1 0000002a 0000
# next frame right after, NS flag set, presence flags must be clear
frame 6 22
00 16 c0 01 00 00 01 00 de ad be f0 51 11 72 10 0b ad 00 00
0d 0a
expect 0016 c001 00000100 deadbef0 111 7210 0 0 0000 0 00 0 0 0 00000000 0002
# offset nibble 3, parsed as a 20-byte header
frame 6 23
12 34 56 78 0a 0b 0c 0d 00 00 00 01 30 04 00 00 ff ff 00 00
01 02 03
expect 1234 5678 0a0b0c0d 00000001 004 0000 1 0 0000 0 00 0 0 0 00000000 0003

// ==== sources.f ====
verilog/tcp_rx_pkg.sv
verilog/ipv4_proto_filter.sv
verilog/tcp_hdr_parser.sv
verilog/tcp_opt_parser.sv
verilog/tcp_pld_strm.sv
verilog/tcp_rx_top.sv
tb/tcp_rx_sva.sv
tb/tcp_rx_checker.sv
tb/tcp_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f sources.f --top-module tcp_rx_tb -o tcp_rx_sim &&
./obj_dir/tcp_rx_sim +verilator+error+limit+100 | tee /dev/stderr |
  grep -qx "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
